//--- files.f
src/mmu_pkg.sv
src/cache_port_ctrl.sv
src/refill_arbiter.sv
src/mmu_top.sv
testbench/mmu_properties.sv
testbench/mmu_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module mmu_tb -f files.f

./obj_dir/Vmmu_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

//--- testbench/mmu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_tb;

    import mmu_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic                  clk_i;
    logic                  rst_n_i;

    logic                  dc_miss_i;
    logic [ADDR_SIZE-1:0]  dc_addr_i;
    logic                  dc_access_i;
    logic                  dc_hit_i;
    logic                  dc_store_i;
    logic [WORD_SIZE-1:0]  dc_store_data_i;
    store_size_e           dc_store_size_i;
    logic                  dc_refill_rdy_o;
    logic [LANE_SIZE-1:0]  dc_refill_data_o;
    logic [INDEX_SIZE-1:0] dc_victim_idx_o;

    logic                  ic_miss_i;
    logic [ADDR_SIZE-1:0]  ic_addr_i;
    logic                  ic_access_i;
    logic                  ic_hit_i;
    logic                  ic_refill_rdy_o;
    logic [LANE_SIZE-1:0]  ic_refill_data_o;
    logic [INDEX_SIZE-1:0] ic_victim_idx_o;

    logic                  mm_rd_req_o;
    logic [ADDR_SIZE-1:0]  mm_rd_addr_o;
    logic                  mm_data_rdy_i;
    logic [LANE_SIZE-1:0]  mm_data_i;
    logic                  mm_wr_req_o;
    logic [ADDR_SIZE-1:0]  mm_wr_addr_o;
    logic [WORD_SIZE-1:0]  mm_wr_data_o;
    store_size_e           mm_wr_size_o;

    // Expected line reads in service order
    // Port 0 is the data cache
    logic [ADDR_SIZE-1:0]  exp_addr_q[$];
    logic                  exp_port_q[$];
    logic [ADDR_SIZE-1:0]  cur_addr;
    logic                  cur_port;
    logic                  cur_valid;
    int                    issued_cnt[2];
    int                    done_cnt[2];

    logic [2:0]            ref_tree_dc;
    logic [2:0]            ref_tree_ic;

    logic                  prev_data_rdy;
    logic                  prev_store;
    logic [ADDR_SIZE-1:0]  prev_store_addr;
    logic [WORD_SIZE-1:0]  prev_store_data;
    store_size_e           prev_store_size;

    int                    delays[64];

    mmu_top mmu_top_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [LANE_SIZE-1:0] line_of(input logic [ADDR_SIZE-1:0] addr);
        logic [LANE_SIZE-1:0] line;

        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = addr + 32'(i);
        end
        return line;
    endfunction

    // Bit 0 picks the half and bits 1 and 2 the lane within it
    function automatic logic [1:0] ref_victim(input logic [2:0] tree);
        if (tree[0] == 1'b0) begin
            return tree[1] ? 2'd1 : 2'd0;
        end else begin
            return tree[2] ? 2'd3 : 2'd2;
        end
    endfunction

    function automatic logic [2:0] ref_touch(input logic [2:0] tree, input logic [1:0] lane);
        logic [2:0] t;

        t = tree;
        case (lane)
            2'd0: begin
                t[0] = 1'b1;
                t[1] = 1'b1;
            end
            2'd1: begin
                t[0] = 1'b1;
                t[1] = 1'b0;
            end
            2'd2: begin
                t[0] = 1'b0;
                t[2] = 1'b1;
            end
            default: begin
                t[0] = 1'b0;
                t[2] = 1'b0;
            end
        endcase
        return t;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] expected,
                                   input logic [127:0] actual);
        $display("ERR %s expected 0x%0h got 0x%0h", name, expected, actual);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    // Main memory model with a random delay per line read
    initial begin
        int   left;
        int   n;
        logic busy;
        logic [ADDR_SIZE-1:0] addr;

        mm_data_rdy_i = 1'b0;
        mm_data_i     = '0;
        busy          = 1'b0;
        left          = 0;
        n             = 0;
        addr          = '0;
        forever begin
            @(posedge clk_i);
            mm_data_rdy_i <= 1'b0;
            if (!rst_n_i) begin
                busy = 1'b0;
            end else if (mm_rd_req_o) begin
                addr = mm_rd_addr_o;
                left = delays[n % 64];
                n++;
                busy = 1'b1;
            end else if (busy) begin
                left--;
                if (left == 0) begin
                    mm_data_rdy_i <= 1'b1;
                    mm_data_i     <= line_of(addr);
                    busy = 1'b0;
                end
            end
        end
    end

    task automatic check_refills();
        logic any_rdy;

        any_rdy = dc_refill_rdy_o | ic_refill_rdy_o;
        assert (any_rdy == prev_data_rdy)
            else report_mismatch("refill_rdy_o", 128'(prev_data_rdy), 128'(any_rdy));
        if (any_rdy) begin
            if (!cur_valid) begin
                fail_plain("A refill was delivered with no line read outstanding");
            end else begin
                assert (dc_refill_rdy_o == !cur_port)
                    else report_mismatch("dc_refill_rdy_o", 128'(!cur_port),
                                         128'(dc_refill_rdy_o));
                assert (ic_refill_rdy_o == cur_port)
                    else report_mismatch("ic_refill_rdy_o", 128'(cur_port),
                                         128'(ic_refill_rdy_o));
                if (cur_port == 1'b0) begin
                    assert (dc_refill_data_o == line_of(cur_addr))
                        else report_mismatch("dc_refill_data_o", line_of(cur_addr),
                                             dc_refill_data_o);
                end else begin
                    assert (ic_refill_data_o == line_of(cur_addr))
                        else report_mismatch("ic_refill_data_o", line_of(cur_addr),
                                             ic_refill_data_o);
                end
                done_cnt[cur_port] = done_cnt[cur_port] + 1;
                cur_valid = 1'b0;
            end
        end
    endtask

    task automatic check_reads();
        logic [ADDR_SIZE-1:0] exp_addr;

        if (mm_rd_req_o) begin
            if (cur_valid) begin
                fail_plain("A second line read was issued while one was outstanding");
            end else if (exp_addr_q.size() == 0) begin
                fail_plain("A line read was issued with no miss waiting for it");
            end else begin
                exp_addr = exp_addr_q.pop_front();
                cur_port = exp_port_q.pop_front();
                assert (mm_rd_addr_o == exp_addr)
                    else report_mismatch("mm_rd_addr_o", 128'(exp_addr), 128'(mm_rd_addr_o));
                cur_addr  = exp_addr;
                cur_valid = 1'b1;
            end
        end
    endtask

    task automatic check_victims();
        assert (dc_victim_idx_o == ref_victim(ref_tree_dc))
            else report_mismatch("dc_victim_idx_o", 128'(ref_victim(ref_tree_dc)),
                                 128'(dc_victim_idx_o));
        assert (ic_victim_idx_o == ref_victim(ref_tree_ic))
            else report_mismatch("ic_victim_idx_o", 128'(ref_victim(ref_tree_ic)),
                                 128'(ic_victim_idx_o));
        // Refill wins over a hit in the same cycle
        if (dc_refill_rdy_o) begin
            ref_tree_dc = ref_touch(ref_tree_dc, ref_victim(ref_tree_dc));
        end else if (dc_access_i && dc_hit_i) begin
            ref_tree_dc = ref_touch(ref_tree_dc, dc_addr_i[5:4]);
        end
        if (ic_refill_rdy_o) begin
            ref_tree_ic = ref_touch(ref_tree_ic, ref_victim(ref_tree_ic));
        end else if (ic_access_i && ic_hit_i) begin
            ref_tree_ic = ref_touch(ref_tree_ic, ic_addr_i[5:4]);
        end
    endtask

    task automatic check_stores();
        assert (mm_wr_req_o == prev_store)
            else report_mismatch("mm_wr_req_o", 128'(prev_store), 128'(mm_wr_req_o));
        if (prev_store) begin
            assert (mm_wr_addr_o == prev_store_addr)
                else report_mismatch("mm_wr_addr_o", 128'(prev_store_addr), 128'(mm_wr_addr_o));
            assert (mm_wr_data_o == prev_store_data)
                else report_mismatch("mm_wr_data_o", 128'(prev_store_data), 128'(mm_wr_data_o));
            assert (mm_wr_size_o == prev_store_size)
                else report_mismatch("mm_wr_size_o", 128'(prev_store_size), 128'(mm_wr_size_o));
        end
    endtask

    // Checks run at each falling edge
    initial begin
        cur_valid     = 1'b0;
        cur_port      = 1'b0;
        cur_addr      = '0;
        done_cnt[0]   = 0;
        done_cnt[1]   = 0;
        ref_tree_dc   = '0;
        ref_tree_ic   = '0;
        forever begin
            @(negedge clk_i);
            if (!rst_n_i) begin
                ref_tree_dc = '0;
                ref_tree_ic = '0;
            end else begin
                check_refills();
                check_reads();
                check_victims();
                check_stores();
            end
            prev_data_rdy   = mm_data_rdy_i;
            prev_store      = dc_store_i;
            prev_store_addr = dc_addr_i;
            prev_store_data = dc_store_data_i;
            prev_store_size = dc_store_size_i;
        end
    end

    task automatic issue_miss(input logic port, input logic [ADDR_SIZE-1:0] addr);
        @(posedge clk_i);
        if (port == 1'b0) begin
            dc_miss_i <= 1'b1;
            dc_addr_i <= addr;
        end else begin
            ic_miss_i <= 1'b1;
            ic_addr_i <= addr;
        end
        exp_addr_q.push_back({addr[ADDR_SIZE-1:4], 4'h0});
        exp_port_q.push_back(port);
        issued_cnt[port] = issued_cnt[port] + 1;
        @(posedge clk_i);
        dc_miss_i <= 1'b0;
        ic_miss_i <= 1'b0;
    endtask

    task automatic issue_both(input logic [ADDR_SIZE-1:0] dc_addr,
                              input logic [ADDR_SIZE-1:0] ic_addr);
        @(posedge clk_i);
        dc_miss_i <= 1'b1;
        dc_addr_i <= dc_addr;
        ic_miss_i <= 1'b1;
        ic_addr_i <= ic_addr;
        exp_addr_q.push_back({dc_addr[ADDR_SIZE-1:4], 4'h0});
        exp_port_q.push_back(1'b0);
        exp_addr_q.push_back({ic_addr[ADDR_SIZE-1:4], 4'h0});
        exp_port_q.push_back(1'b1);
        issued_cnt[0] = issued_cnt[0] + 1;
        issued_cnt[1] = issued_cnt[1] + 1;
        @(posedge clk_i);
        dc_miss_i <= 1'b0;
        ic_miss_i <= 1'b0;
    endtask

    task automatic wait_refill(input logic port);
        int n;

        n = 0;
        while (done_cnt[port] < issued_cnt[port] && n < WAIT_LIMIT) begin
            @(posedge clk_i);
            n++;
        end
        if (done_cnt[port] < issued_cnt[port]) begin
            if (port) begin
                fail_plain("Timed out waiting for an instruction cache refill");
            end else begin
                fail_plain("Timed out waiting for a data cache refill");
            end
        end
    endtask

    task automatic drive_hits(input int cycles);
        logic [31:0] rnd;

        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_i);
            rnd = $urandom;
            dc_access_i <= rnd[0];
            dc_hit_i    <= rnd[1] | rnd[2];
            dc_addr_i   <= $urandom;
            ic_access_i <= rnd[3];
            ic_hit_i    <= rnd[4] | rnd[5];
            ic_addr_i   <= $urandom;
        end
        @(posedge clk_i);
        dc_access_i <= 1'b0;
        dc_hit_i    <= 1'b0;
        ic_access_i <= 1'b0;
        ic_hit_i    <= 1'b0;
    endtask

    task automatic drive_stores(input int cycles);
        logic [31:0] rnd;

        for (int i = 0; i < cycles; i++) begin
            @(posedge clk_i);
            rnd = $urandom;
            dc_store_i      <= (i < 6) ? 1'b1 : rnd[0];
            dc_store_size_i <= store_size_e'(i % 3);
            dc_addr_i       <= $urandom;
            dc_store_data_i <= $urandom;
        end
        @(posedge clk_i);
        dc_store_i <= 1'b0;
    endtask

    task automatic check_idle();
        assert (mm_rd_req_o == 1'b0) else report_mismatch("mm_rd_req_o", 0, 128'(mm_rd_req_o));
        assert (mm_wr_req_o == 1'b0) else report_mismatch("mm_wr_req_o", 0, 128'(mm_wr_req_o));
        assert (dc_refill_rdy_o == 1'b0)
            else report_mismatch("dc_refill_rdy_o", 0, 128'(dc_refill_rdy_o));
        assert (ic_refill_rdy_o == 1'b0)
            else report_mismatch("ic_refill_rdy_o", 0, 128'(ic_refill_rdy_o));
        assert (mmu_top_i.dc_pending == 1'b0)
            else report_mismatch("dc_pending", 0, 128'(mmu_top_i.dc_pending));
        assert (mmu_top_i.ic_pending == 1'b0)
            else report_mismatch("ic_pending", 0, 128'(mmu_top_i.ic_pending));
        assert (dc_victim_idx_o == 2'd0)
            else report_mismatch("dc_victim_idx_o", 0, 128'(dc_victim_idx_o));
        assert (ic_victim_idx_o == 2'd0)
            else report_mismatch("ic_victim_idx_o", 0, 128'(ic_victim_idx_o));
    endtask

    initial begin
        int n;

        void'($urandom(61));
        for (int i = 0; i < 64; i++) begin
            delays[i] = 1 + int'($urandom % 8);
        end
        rst_n_i         = 1'b0;
        dc_miss_i       = 1'b0;
        dc_addr_i       = '0;
        dc_access_i     = 1'b0;
        dc_hit_i        = 1'b0;
        dc_store_i      = 1'b0;
        dc_store_data_i = '0;
        dc_store_size_i = SIZE_BYTE;
        ic_miss_i       = 1'b0;
        ic_addr_i       = '0;
        ic_access_i     = 1'b0;
        ic_hit_i        = 1'b0;
        issued_cnt[0]   = 0;
        issued_cnt[1]   = 0;

        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_idle();

        // Single misses on each port
        issue_miss(1'b0, 32'h1234_567c);
        wait_refill(1'b0);
        issue_miss(1'b1, 32'h0000_2f3a);
        wait_refill(1'b1);

        // Priority and alternation
        issue_both(32'h0001_0004, 32'h0002_0008);
        wait_refill(1'b0);
        wait_refill(1'b1);
        issue_miss(1'b0, 32'h0003_0010);
        issue_miss(1'b1, 32'h0004_0020);
        wait_refill(1'b0);
        issue_miss(1'b0, 32'h0005_0030);
        wait_refill(1'b1);
        wait_refill(1'b0);
        issue_miss(1'b1, 32'h0006_0040);
        issue_miss(1'b0, 32'h0007_0050);
        wait_refill(1'b1);
        issue_miss(1'b1, 32'h0008_0060);
        wait_refill(1'b0);
        wait_refill(1'b1);

        // Pseudo-LRU under random hits and refills
        drive_hits(60);
        issue_miss(1'b0, 32'h0009_0070);
        wait_refill(1'b0);
        issue_miss(1'b1, 32'h000a_0080);
        wait_refill(1'b1);
        drive_hits(20);

        // Stores with a refill outstanding
        issue_miss(1'b0, 32'h0000_8a40);
        drive_stores(30);
        wait_refill(1'b0);

        n = 0;
        while ((exp_addr_q.size() != 0 || cur_valid) && n < WAIT_LIMIT) begin
            @(posedge clk_i);
            n++;
        end
        repeat (4) @(posedge clk_i);
        if (exp_addr_q.size() != 0 || cur_valid) begin
            fail_plain("Timed out waiting for the remaining line reads to finish");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule : mmu_tb

`default_nettype wire

//--- testbench/mmu_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_properties (
    input logic                          clk_i,
    input logic                          rst_n_i,
    input logic                          rd_req_i,
    input logic                          dc_rdy_i,
    input logic                          ic_rdy_i,
    input logic                          data_rdy_i,
    input logic                          store_i,
    input logic [mmu_pkg::ADDR_SIZE-1:0] store_addr_i,
    input logic [mmu_pkg::WORD_SIZE-1:0] store_data_i,
    input mmu_pkg::store_size_e          store_size_i,
    input logic                          wr_req_i,
    input logic [mmu_pkg::ADDR_SIZE-1:0] wr_addr_i,
    input logic [mmu_pkg::WORD_SIZE-1:0] wr_data_i,
    input mmu_pkg::store_size_e          wr_size_i
);

    // One strobe per refill
    a_rd_req_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_req_i |=> !rd_req_i)
        else $error("line read strobe high on two consecutive cycles");

    a_refill_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(dc_rdy_i && ic_rdy_i))
        else $error("both caches given a refill in the same cycle");

    a_refill_follows: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (dc_rdy_i || ic_rdy_i) == $past(data_rdy_i))
        else $error("refill ready does not follow memory data ready by one cycle");

    a_store_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wr_req_i == $past(store_i))
        else $error("write request does not follow store strobe");

    a_store_fields: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(store_i) |-> (wr_addr_i == $past(store_addr_i)
                            && wr_data_i == $past(store_data_i)
                            && wr_size_i == $past(store_size_i)))
        else $error("write address, data or size differ from the store one cycle earlier");

endmodule : mmu_properties

bind mmu_top mmu_properties u_mmu_properties (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rd_req_i     (mm_rd_req_o),
    .dc_rdy_i     (dc_refill_rdy_o),
    .ic_rdy_i     (ic_refill_rdy_o),
    .data_rdy_i   (mm_data_rdy_i),
    .store_i      (dc_store_i),
    .store_addr_i (dc_addr_i),
    .store_data_i (dc_store_data_i),
    .store_size_i (dc_store_size_i),
    .wr_req_i     (mm_wr_req_o),
    .wr_addr_i    (mm_wr_addr_o),
    .wr_data_i    (mm_wr_data_o),
    .wr_size_i    (mm_wr_size_o)
);

`default_nettype wire

//--- src/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_top (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // Data cache
    input  logic                           dc_miss_i,
    input  logic [mmu_pkg::ADDR_SIZE-1:0]  dc_addr_i,
    input  logic                           dc_access_i,
    input  logic                           dc_hit_i,
    input  logic                           dc_store_i,
    input  logic [mmu_pkg::WORD_SIZE-1:0]  dc_store_data_i,
    input  mmu_pkg::store_size_e           dc_store_size_i,
    output logic                           dc_refill_rdy_o,
    output logic [mmu_pkg::LANE_SIZE-1:0]  dc_refill_data_o,
    output logic [mmu_pkg::INDEX_SIZE-1:0] dc_victim_idx_o,

    // Instruction cache
    input  logic                           ic_miss_i,
    input  logic [mmu_pkg::ADDR_SIZE-1:0]  ic_addr_i,
    input  logic                           ic_access_i,
    input  logic                           ic_hit_i,
    output logic                           ic_refill_rdy_o,
    output logic [mmu_pkg::LANE_SIZE-1:0]  ic_refill_data_o,
    output logic [mmu_pkg::INDEX_SIZE-1:0] ic_victim_idx_o,

    // Main memory
    output logic                           mm_rd_req_o,
    output logic [mmu_pkg::ADDR_SIZE-1:0]  mm_rd_addr_o,
    input  logic                           mm_data_rdy_i,
    input  logic [mmu_pkg::LANE_SIZE-1:0]  mm_data_i,
    output logic                           mm_wr_req_o,
    output logic [mmu_pkg::ADDR_SIZE-1:0]  mm_wr_addr_o,
    output logic [mmu_pkg::WORD_SIZE-1:0]  mm_wr_data_o,
    output mmu_pkg::store_size_e           mm_wr_size_o
);

    import mmu_pkg::*;

    logic                 dc_pending;
    logic [ADDR_SIZE-1:0] dc_line_addr;
    logic                 ic_pending;
    logic [ADDR_SIZE-1:0] ic_line_addr;
    logic [LANE_SIZE-1:0] refill_data;

    cache_port_ctrl u_dc_port (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .miss_i        (dc_miss_i),
        .addr_i        (dc_addr_i),
        .access_i      (dc_access_i),
        .hit_i         (dc_hit_i),
        .victim_idx_o  (dc_victim_idx_o),
        .refill_done_i (dc_refill_rdy_o),
        .pending_o     (dc_pending),
        .line_addr_o   (dc_line_addr)
    );

    cache_port_ctrl u_ic_port (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .miss_i        (ic_miss_i),
        .addr_i        (ic_addr_i),
        .access_i      (ic_access_i),
        .hit_i         (ic_hit_i),
        .victim_idx_o  (ic_victim_idx_o),
        .refill_done_i (ic_refill_rdy_o),
        .pending_o     (ic_pending),
        .line_addr_o   (ic_line_addr)
    );

    refill_arbiter u_arbiter (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .dc_pending_i     (dc_pending),
        .dc_line_addr_i   (dc_line_addr),
        .ic_pending_i     (ic_pending),
        .ic_line_addr_i   (ic_line_addr),
        .dc_refill_done_o (dc_refill_rdy_o),
        .ic_refill_done_o (ic_refill_rdy_o),
        .refill_data_o    (refill_data),
        .mm_rd_req_o      (mm_rd_req_o),
        .mm_rd_addr_o     (mm_rd_addr_o),
        .mm_data_rdy_i    (mm_data_rdy_i),
        .mm_data_i        (mm_data_i),
        .dc_store_i       (dc_store_i),
        .dc_store_addr_i  (dc_addr_i),
        .dc_store_data_i  (dc_store_data_i),
        .dc_store_size_i  (dc_store_size_i),
        .mm_wr_req_o      (mm_wr_req_o),
        .mm_wr_addr_o     (mm_wr_addr_o),
        .mm_wr_data_o     (mm_wr_data_o),
        .mm_wr_size_o     (mm_wr_size_o)
    );

    // One refill line register feeds both caches
    assign dc_refill_data_o = refill_data;
    assign ic_refill_data_o = refill_data;

endmodule : mmu_top

`default_nettype wire

//--- src/refill_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module refill_arbiter (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // Port controllers
    input  logic                           dc_pending_i,
    input  logic [mmu_pkg::ADDR_SIZE-1:0]  dc_line_addr_i,
    input  logic                           ic_pending_i,
    input  logic [mmu_pkg::ADDR_SIZE-1:0]  ic_line_addr_i,
    output logic                           dc_refill_done_o,
    output logic                           ic_refill_done_o,
    output logic [mmu_pkg::LANE_SIZE-1:0]  refill_data_o,

    // Main memory read
    output logic                           mm_rd_req_o,
    output logic [mmu_pkg::ADDR_SIZE-1:0]  mm_rd_addr_o,
    input  logic                           mm_data_rdy_i,
    input  logic [mmu_pkg::LANE_SIZE-1:0]  mm_data_i,

    // Data cache stores
    input  logic                           dc_store_i,
    input  logic [mmu_pkg::ADDR_SIZE-1:0]  dc_store_addr_i,
    input  logic [mmu_pkg::WORD_SIZE-1:0]  dc_store_data_i,
    input  mmu_pkg::store_size_e           dc_store_size_i,

    // Main memory write-through
    output logic                           mm_wr_req_o,
    output logic [mmu_pkg::ADDR_SIZE-1:0]  mm_wr_addr_o,
    output logic [mmu_pkg::WORD_SIZE-1:0]  mm_wr_data_o,
    output mmu_pkg::store_size_e           mm_wr_size_o
);

    import mmu_pkg::*;

    arb_state_e           state_q;
    arb_state_e           state_d;

    logic                 rd_req_d;
    logic [ADDR_SIZE-1:0] rd_addr_d;
    logic                 dc_data_take;
    logic                 ic_data_take;

    // Data cache first from idle, then alternate after each refill
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (dc_pending_i) begin
                    state_d = ARB_DC_REQ;
                end else if (ic_pending_i) begin
                    state_d = ARB_IC_REQ;
                end
            end
            ARB_DC_REQ: begin
                state_d = ARB_DC_WAIT;
            end
            ARB_DC_WAIT: begin
                if (mm_data_rdy_i) begin
                    if (ic_pending_i) begin
                        state_d = ARB_IC_REQ;
                    end else begin
                        state_d = ARB_IDLE;
                    end
                end
            end
            ARB_IC_REQ: begin
                state_d = ARB_IC_WAIT;
            end
            ARB_IC_WAIT: begin
                if (mm_data_rdy_i) begin
                    if (dc_pending_i) begin
                        state_d = ARB_DC_REQ;
                    end else begin
                        state_d = ARB_IDLE;
                    end
                end
            end
            default: begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    // One read strobe per REQ state, issued the cycle after
    assign rd_req_d  = (state_q == ARB_DC_REQ) || (state_q == ARB_IC_REQ);
    assign rd_addr_d = (state_q == ARB_IC_REQ) ? ic_line_addr_i : dc_line_addr_i;

    // Returning lines only count while waiting on them
    assign dc_data_take = (state_q == ARB_DC_WAIT) && mm_data_rdy_i;
    assign ic_data_take = (state_q == ARB_IC_WAIT) && mm_data_rdy_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q          <= ARB_IDLE;
            mm_rd_req_o      <= 1'b0;
            dc_refill_done_o <= 1'b0;
            ic_refill_done_o <= 1'b0;
        end else begin
            state_q          <= state_d;
            mm_rd_req_o      <= rd_req_d;
            dc_refill_done_o <= dc_data_take;
            ic_refill_done_o <= ic_data_take;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_req_d) begin
            mm_rd_addr_o <= rd_addr_d;
        end
        if (dc_data_take || ic_data_take) begin
            refill_data_o <= mm_data_i;
        end
    end

    // Write-through stage beside the refill path
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mm_wr_req_o <= 1'b0;
        end else begin
            mm_wr_req_o <= dc_store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        mm_wr_addr_o <= dc_store_addr_i;
        mm_wr_data_o <= dc_store_data_i;
        mm_wr_size_o <= dc_store_size_i;
    end

endmodule : refill_arbiter

`default_nettype wire

//--- src/cache_port_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_port_ctrl (
    input  logic                           clk_i,
    input  logic                           rst_n_i,

    // Cache side
    input  logic                           miss_i,
    input  logic [mmu_pkg::ADDR_SIZE-1:0]  addr_i,
    input  logic                           access_i,
    input  logic                           hit_i,
    output logic [mmu_pkg::INDEX_SIZE-1:0] victim_idx_o,

    // Arbiter side
    input  logic                           refill_done_i,
    output logic                           pending_o,
    output logic [mmu_pkg::ADDR_SIZE-1:0]  line_addr_o
);

    import mmu_pkg::*;

    logic                  pending_q;
    logic [ADDR_SIZE-1:0]  line_addr_q;

    logic [PLRU_SIZE-1:0]  plru_q;
    logic [PLRU_SIZE-1:0]  plru_d;

    logic [INDEX_SIZE-1:0] hit_lane;
    logic [INDEX_SIZE-1:0] touch_lane;
    logic                  touch_en;

    // Point every tree bit on the path away from the touched lane
    function automatic logic [PLRU_SIZE-1:0] plru_touch(
        input logic [PLRU_SIZE-1:0]  tree,
        input logic [INDEX_SIZE-1:0] lane
    );
        logic [PLRU_SIZE-1:0] tree_nxt;

        tree_nxt    = tree;
        tree_nxt[0] = ~lane[1];
        if (lane[1]) begin
            tree_nxt[2] = ~lane[0];
        end else begin
            tree_nxt[1] = ~lane[0];
        end
        return tree_nxt;
    endfunction

    // Follow the tree bits down to the victim lane
    function automatic logic [INDEX_SIZE-1:0] plru_victim(
        input logic [PLRU_SIZE-1:0] tree
    );
        logic [INDEX_SIZE-1:0] lane;

        lane[1] = tree[0];
        if (tree[0]) begin
            lane[0] = tree[2];
        end else begin
            lane[0] = tree[1];
        end
        return lane;
    endfunction

    // Lane index sits just above the line offset
    assign hit_lane = addr_i[OFFSET_SIZE +: INDEX_SIZE];

    assign victim_idx_o = plru_victim(plru_q);

    // Refill fills the victim lane, so it becomes most recently used
    always_comb begin
        touch_en   = 1'b0;
        touch_lane = hit_lane;
        if (refill_done_i) begin
            touch_en   = 1'b1;
            touch_lane = victim_idx_o;
        end else if (access_i && hit_i) begin
            touch_en   = 1'b1;
        end
    end

    always_comb begin
        if (touch_en) begin
            plru_d = plru_touch(plru_q, touch_lane);
        end else begin
            plru_d = plru_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
            plru_q    <= '0;
        end else begin
            if (miss_i) begin
                pending_q <= 1'b1;
            end else if (refill_done_i) begin
                pending_q <= 1'b0;
            end
            plru_q <= plru_d;
        end
    end

    // Miss address aligned to the start of its line
    always_ff @(posedge clk_i) begin
        if (miss_i) begin
            line_addr_q <= {addr_i[ADDR_SIZE-1:OFFSET_SIZE], {OFFSET_SIZE{1'b0}}};
        end
    end

    // Drops in the cycle the refill is handed back
    assign pending_o   = pending_q & ~refill_done_i;
    assign line_addr_o = line_addr_q;

endmodule : cache_port_ctrl

`default_nettype wire

//--- src/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

    // Address and data path widths
    localparam int ADDR_SIZE = 32;
    localparam int WORD_SIZE = 32;

    // Line geometry, 16-byte lines
    localparam int LANE_SIZE   = 128;
    localparam int OFFSET_SIZE = $clog2(LANE_SIZE / 8);

    // Lanes per cache and the tree pseudo-LRU that covers them
    localparam int NUM_LANES  = 4;
    localparam int INDEX_SIZE = $clog2(NUM_LANES);
    localparam int PLRU_SIZE  = NUM_LANES - 1;

    // Width of a write-through store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } store_size_e;

    // Refill arbiter states
    typedef enum logic [2:0] {
        ARB_IDLE    = 3'd0,
        ARB_DC_REQ  = 3'd1,
        ARB_DC_WAIT = 3'd2,
        ARB_IC_REQ  = 3'd3,
        ARB_IC_WAIT = 3'd4
    } arb_state_e;

endpackage : mmu_pkg

`default_nettype wire
